// ==== Bender.yml ====
package:
  name: chitchat_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/chitchat_pkg.sv
      - logic/chitchat_frame_timer.sv
      - logic/chitchat_tx_buffer.sv
      - logic/chitchat_tx_fsm.sv
      - logic/chitchat_rx_decoder.sv
      - logic/chitchat_link.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/chitchat_link_properties.sv
      - test/chitchat_link_tb.sv

// ==== chitchat_link.f ====
+incdir+logic
logic/chitchat_pkg.sv
logic/chitchat_frame_timer.sv
logic/chitchat_tx_buffer.sv
logic/chitchat_tx_fsm.sv
logic/chitchat_rx_decoder.sv
logic/chitchat_link.sv
test/chitchat_link_properties.sv
test/chitchat_link_tb.sv

// ==== logic/chitchat_consts.svh ====
/*
 * Link constants: protocol version, comma byte, frame geometry,
 * TX buffer depth and loss-of-signal timeout
 */
`ifndef CHITCHAT_CONSTS_SVH
`define CHITCHAT_CONSTS_SVH

// Frame format
`define CC_PROTOCOL_VER 4'd1
`define CC_COMMA        8'hBC
`define CC_FRAME_WORDS  9

// Cycles between frame starts
`define CC_FRAME_PERIOD 12

// Payload entries, also the credit count
`define CC_TX_DEPTH     4

// Cycles without a comma before LOS
`define CC_LOS_TIMEOUT  40

`endif

// ==== logic/chitchat_frame_timer.sv ====
/*
 * Frame period tick, local frame counter and LOS watchdog
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_frame_timer (
   input  logic        gtx_tx_clk,
   input  logic        rst,
   input  logic        frame_start,
   input  logic        comma_seen,
   output logic        frame_tick,
   output logic [15:0] local_frame_counter,
   output logic        ccrx_los
);

   localparam int PERIOD_W = $clog2(`CC_FRAME_PERIOD);
   localparam int LOS_W    = $clog2(`CC_LOS_TIMEOUT + 1);

   logic [PERIOD_W-1:0] period_q;
   logic [LOS_W-1:0]    los_q;

   assign frame_tick = (period_q == PERIOD_W'(`CC_FRAME_PERIOD - 1));

   // Watchdog saturates at the timeout
   assign ccrx_los = (los_q >= LOS_W'(`CC_LOS_TIMEOUT));

   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         period_q            <= '0;
         local_frame_counter <= '0;
         // Start in LOS until the first comma shows up
         los_q               <= LOS_W'(`CC_LOS_TIMEOUT);
      end else begin
         period_q <= frame_tick ? '0 : period_q + 1'b1;
         if (frame_start)
            local_frame_counter <= local_frame_counter + 16'd1;
         if (comma_seen)
            los_q <= '0;
         else if (!ccrx_los)
            los_q <= los_q + 1'b1;
      end
   end

endmodule

// ==== logic/chitchat_link.sv ====
/*
 * Link top: frame timer, TX buffer, TX FSM and RX decoder
 */
`timescale 1ns/1ps

module chitchat_link
   import chitchat_pkg::*;
#(
   parameter logic [2:0] GATEWARE_TYPE = 3'd0
) (
   input  logic        gtx_tx_clk,
   input  logic        rst,
   input  logic        tx_transmit_en,
   input  logic [2:0]  tx_location,
   input  logic        tx_valid,
   input  cc_payload_t tx_payload,
   output logic        tx_credit,
   output logic        rx_valid,
   output cc_payload_t rx_payload,
   output cc_rx_info_t rx_info,
   output logic [15:0] txrx_latency,
   output logic        ccrx_frame_drop,
   output cc_fault_e   ccrx_fault,
   output logic [15:0] ccrx_fault_cnt,
   output logic        ccrx_los,
   output logic [15:0] gtx_tx_d,
   output logic [1:0]  gtx_tx_k,
   input  logic [15:0] gtx_rx_d,
   input  logic [1:0]  gtx_rx_k
);

   logic        frame_tick;
   logic        frame_start;
   logic        comma_seen;
   logic [15:0] local_frame_counter;
   logic [15:0] loopback_counter;
   logic        pop;
   logic        empty;
   cc_payload_t head;
   cc_lane_t    tx_lane;
   cc_lane_t    rx_lane;

   // Lane split and merge
   assign gtx_tx_d = tx_lane.d;
   assign gtx_tx_k = tx_lane.k;
   assign rx_lane  = '{d: gtx_rx_d, k: gtx_rx_k};

   chitchat_frame_timer u_timer (
      .gtx_tx_clk          (gtx_tx_clk),
      .rst                 (rst),
      .frame_start         (frame_start),
      .comma_seen          (comma_seen),
      .frame_tick          (frame_tick),
      .local_frame_counter (local_frame_counter),
      .ccrx_los            (ccrx_los)
   );

   chitchat_tx_buffer u_tx_buffer (
      .gtx_tx_clk (gtx_tx_clk),
      .rst        (rst),
      .tx_valid   (tx_valid),
      .tx_payload (tx_payload),
      .pop        (pop),
      .head       (head),
      .empty      (empty),
      .tx_credit  (tx_credit)
   );

   chitchat_tx_fsm #(
      .GATEWARE_TYPE (GATEWARE_TYPE)
   ) u_tx_fsm (
      .gtx_tx_clk          (gtx_tx_clk),
      .rst                 (rst),
      .tx_transmit_en      (tx_transmit_en),
      .tx_location         (tx_location),
      .frame_tick          (frame_tick),
      .empty               (empty),
      .head                (head),
      .local_frame_counter (local_frame_counter),
      .loopback_counter    (loopback_counter),
      .pop                 (pop),
      .frame_start         (frame_start),
      .tx_lane             (tx_lane)
   );

   chitchat_rx_decoder u_rx_decoder (
      .gtx_tx_clk          (gtx_tx_clk),
      .rst                 (rst),
      .rx_lane             (rx_lane),
      .local_frame_counter (local_frame_counter),
      .comma_seen          (comma_seen),
      .loopback_counter    (loopback_counter),
      .rx_valid            (rx_valid),
      .rx_payload          (rx_payload),
      .rx_info             (rx_info),
      .txrx_latency        (txrx_latency),
      .ccrx_frame_drop     (ccrx_frame_drop),
      .ccrx_fault          (ccrx_fault),
      .ccrx_fault_cnt      (ccrx_fault_cnt)
   );

endmodule

// ==== logic/chitchat_pkg.sv ====
/*
 * Link types: payload, header, lane word and RX status structs,
 * plus the TX/RX state and fault enums
 */
package chitchat_pkg;

   // Two 32-bit words per frame
   typedef struct packed {
      logic [31:0] data0;
      logic [31:0] data1;
   } cc_payload_t;

   // Word 2 of the frame
   typedef struct packed {
      logic [3:0] protocol_ver;
      logic [2:0] gateware_type;
      logic [2:0] location;
      logic       payload_valid;
      logic [4:0] pad;
   } cc_header_t;

   // One transceiver word
   typedef struct packed {
      logic [15:0] d;
      logic [1:0]  k;
   } cc_lane_t;

   // Identity of the far end
   typedef struct packed {
      logic [3:0]  protocol_ver;
      logic [2:0]  gateware_type;
      logic [2:0]  location;
      logic [15:0] rx_frame_counter;
   } cc_rx_info_t;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_COMMA,
      TX_HEADER,
      TX_DATA,
      TX_COUNTERS,
      TX_CHECKSUM
   } cc_tx_state_e;

   typedef enum logic {
      RX_HUNT,
      RX_BODY
   } cc_rx_state_e;

   typedef enum logic [3:0] {
      FAULT_NONE      = 4'd0,
      FAULT_CHECKSUM  = 4'd1,
      FAULT_PROTOCOL  = 4'd2,
      FAULT_TRUNCATED = 4'd3
   } cc_fault_e;

endpackage

// ==== logic/chitchat_rx_decoder.sv ====
/*
 * RX frame parser: comma hunt, checksum and protocol checks,
 * payload and identity outputs, fault counting and latency
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_rx_decoder
   import chitchat_pkg::*;
(
   input  logic        gtx_tx_clk,
   input  logic        rst,
   input  cc_lane_t    rx_lane,
   input  logic [15:0] local_frame_counter,
   output logic        comma_seen,
   output logic [15:0] loopback_counter,
   output logic        rx_valid,
   output cc_payload_t rx_payload,
   output cc_rx_info_t rx_info,
   output logic [15:0] txrx_latency,
   output logic        ccrx_frame_drop,
   output cc_fault_e   ccrx_fault,
   output logic [15:0] ccrx_fault_cnt
);

   // Body index of the checksum word
   localparam logic [2:0] LAST = 3'(`CC_FRAME_WORDS - 2);

   cc_rx_state_e state_q;
   logic [2:0]   cnt_q;
   logic [15:0]  sum_q;
   cc_header_t   hdr_q;
   logic [63:0]  data_q;
   logic [15:0]  fc_q;
   logic [15:0]  lb_q;
   cc_fault_e    fault_now;
   logic         frame_end;
   logic         accept;

   assign comma_seen       = (rx_lane.k == 2'b01) && (rx_lane.d[7:0] == `CC_COMMA);
   assign loopback_counter = rx_info.rx_frame_counter;
   assign accept           = frame_end && (fault_now == FAULT_NONE);

   // ------------------------------
   // Frame checks
   // ------------------------------
   always_comb begin
      fault_now = FAULT_NONE;
      frame_end = 1'b0;
      if (state_q == RX_BODY) begin
         if (comma_seen) begin
            fault_now = FAULT_TRUNCATED;
         end else if (cnt_q == LAST) begin
            frame_end = 1'b1;
            if (rx_lane.d != sum_q)
               fault_now = FAULT_CHECKSUM;
            else if (hdr_q.protocol_ver != `CC_PROTOCOL_VER)
               fault_now = FAULT_PROTOCOL;
         end
      end
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         state_q         <= RX_HUNT;
         cnt_q           <= '0;
         sum_q           <= '0;
         rx_valid        <= 1'b0;
         ccrx_frame_drop <= 1'b0;
         ccrx_fault      <= FAULT_NONE;
         ccrx_fault_cnt  <= '0;
         rx_info         <= '0;
         txrx_latency    <= '0;
      end else begin
         rx_valid        <= accept && hdr_q.payload_valid;
         ccrx_frame_drop <= (fault_now != FAULT_NONE);
         if (fault_now != FAULT_NONE) begin
            ccrx_fault <= fault_now;
            if (ccrx_fault_cnt != 16'hFFFF)
               ccrx_fault_cnt <= ccrx_fault_cnt + 16'd1;
         end
         if (accept) begin
            rx_info <= '{protocol_ver:     hdr_q.protocol_ver,
                         gateware_type:    hdr_q.gateware_type,
                         location:         hdr_q.location,
                         rx_frame_counter: fc_q};
            txrx_latency <= local_frame_counter - lb_q;
         end
         // A comma always restarts, even mid-body
         if (comma_seen) begin
            state_q <= RX_BODY;
            cnt_q   <= '0;
            sum_q   <= '0;
         end else if (state_q == RX_BODY) begin
            if (frame_end) begin
               state_q <= RX_HUNT;
            end else begin
               cnt_q <= cnt_q + 3'd1;
               sum_q <= sum_q + rx_lane.d;
            end
         end
      end
   end

   // Body words land by index
   always_ff @(posedge gtx_tx_clk) begin
      if (state_q == RX_BODY && !comma_seen) begin
         case (cnt_q)
            3'd0: hdr_q <= rx_lane.d;
            3'd1, 3'd2, 3'd3, 3'd4: data_q <= {data_q[47:0], rx_lane.d};
            3'd5: fc_q <= rx_lane.d;
            3'd6: lb_q <= rx_lane.d;
            default: ;
         endcase
      end
      if (accept && hdr_q.payload_valid)
         rx_payload <= data_q;
   end

endmodule

// ==== logic/chitchat_tx_buffer.sv ====
/*
 * TX payload FIFO with credit return, one credit per popped entry
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_tx_buffer
   import chitchat_pkg::*;
(
   input  logic        gtx_tx_clk,
   input  logic        rst,
   input  logic        tx_valid,
   input  cc_payload_t tx_payload,
   input  logic        pop,
   output cc_payload_t head,
   output logic        empty,
   output logic        tx_credit
);

   localparam int PTR_W = $clog2(`CC_TX_DEPTH);
   localparam int CNT_W = $clog2(`CC_TX_DEPTH + 1);

   cc_payload_t      mem [`CC_TX_DEPTH];
   logic [PTR_W-1:0] wr_q;
   logic [PTR_W-1:0] rd_q;
   logic [CNT_W-1:0] count_q;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(`CC_TX_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign head  = mem[rd_q];
   assign empty = (count_q == '0);

   // Storage
   always_ff @(posedge gtx_tx_clk) begin
      if (tx_valid)
         mem[wr_q] <= tx_payload;
   end

   // ------------------------------
   // Pointers, occupancy, credits
   // ------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         wr_q      <= '0;
         rd_q      <= '0;
         count_q   <= '0;
         tx_credit <= 1'b0;
      end else begin
         if (tx_valid)
            wr_q <= next_ptr(wr_q);
         if (pop)
            rd_q <= next_ptr(rd_q);
         case ({tx_valid, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // Credit goes back the cycle after the entry leaves
         tx_credit <= pop;
      end
   end

endmodule

// ==== logic/chitchat_tx_fsm.sv ====
/*
 * TX frame sequencer: comma, header, payload, counters, checksum
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_tx_fsm
   import chitchat_pkg::*;
#(
   parameter logic [2:0] GATEWARE_TYPE = 3'd0
) (
   input  logic        gtx_tx_clk,
   input  logic        rst,
   input  logic        tx_transmit_en,
   input  logic [2:0]  tx_location,
   input  logic        frame_tick,
   input  logic        empty,
   input  cc_payload_t head,
   input  logic [15:0] local_frame_counter,
   input  logic [15:0] loopback_counter,
   output logic        pop,
   output logic        frame_start,
   output cc_lane_t    tx_lane
);

   cc_tx_state_e state_q, next_state;
   logic [1:0]   idx_q, next_idx;
   logic [15:0]  sum_q;
   logic [15:0]  next_word;
   logic [1:0]   next_k;
   logic         add_word;
   logic         pv_q;
   cc_payload_t  pl_q;
   cc_header_t   header;

   assign frame_start = (state_q == TX_IDLE) && frame_tick && tx_transmit_en;
   assign pop         = frame_start && !empty;

   assign header = '{protocol_ver:  `CC_PROTOCOL_VER,
                     gateware_type: GATEWARE_TYPE,
                     location:      tx_location,
                     payload_valid: pv_q,
                     pad:           5'd0};

   // State is the word now on the lane, next_word is the one after it
   always_comb begin
      next_state = state_q;
      next_idx   = idx_q;
      next_word  = 16'd0;
      next_k     = 2'b00;
      add_word   = 1'b1;
      case (state_q)
         TX_IDLE: begin
            add_word = 1'b0;
            if (frame_start) begin
               next_state = TX_COMMA;
               next_word  = {8'h00, `CC_COMMA};
               next_k     = 2'b01;
            end
         end
         TX_COMMA: begin
            next_state = TX_HEADER;
            next_word  = header;
         end
         TX_HEADER: begin
            next_state = TX_DATA;
            next_idx   = 2'd0;
            next_word  = pl_q.data0[31:16];
         end
         TX_DATA: begin
            next_idx = idx_q + 2'd1;
            case (idx_q)
               2'd0: next_word = pl_q.data0[15:0];
               2'd1: next_word = pl_q.data1[31:16];
               2'd2: next_word = pl_q.data1[15:0];
               default: begin
                  next_state = TX_COUNTERS;
                  next_word  = local_frame_counter;
               end
            endcase
         end
         TX_COUNTERS: begin
            if (idx_q == 2'd0) begin
               next_idx  = 2'd1;
               next_word = loopback_counter;
            end else begin
               // Sum already holds words 2 to 8
               next_state = TX_CHECKSUM;
               next_word  = sum_q;
               add_word   = 1'b0;
            end
         end
         default: begin
            next_state = TX_IDLE;
            add_word   = 1'b0;
         end
      endcase
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         state_q <= TX_IDLE;
         idx_q   <= '0;
         sum_q   <= '0;
         pv_q    <= 1'b0;
         tx_lane <= '0;
      end else begin
         state_q <= next_state;
         idx_q   <= next_idx;
         tx_lane <= '{d: next_word, k: next_k};
         if (frame_start) begin
            sum_q <= '0;
            pv_q  <= !empty;
         end else if (add_word) begin
            sum_q <= sum_q + next_word;
         end
      end
   end

   // Empty buffer sends zero data
   always_ff @(posedge gtx_tx_clk) begin
      if (frame_start)
         pl_q <= empty ? '0 : head;
   end

endmodule

// ==== test/chitchat_link_properties.sv ====
/*
 * Link assertions: credit bound, comma framing, reset state, and their bind
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_link_properties (
   input logic        gtx_tx_clk,
   input logic        rst,
   input logic        tx_valid,
   input logic        tx_credit,
   input logic [15:0] gtx_tx_d,
   input logic [1:0]  gtx_tx_k,
   input logic        ccrx_los,
   input logic        rx_valid
);

   logic [3:0] in_flight;
   logic       comma;

   assign comma = (gtx_tx_k == 2'b01) && (gtx_tx_d[7:0] == `CC_COMMA);

   // Entries written but not yet credited back
   always_ff @(posedge gtx_tx_clk) begin
      if (rst)
         in_flight <= '0;
      else
         in_flight <= in_flight + 4'(tx_valid) - 4'(tx_credit);
   end

   credit_bound: assert property (@(posedge gtx_tx_clk) disable iff (rst)
      in_flight <= 4'(`CC_TX_DEPTH))
      else $error("More entries outstanding than the buffer holds");

   comma_framing: assert property (@(posedge gtx_tx_clk) disable iff (rst)
      comma |=> !comma [*(`CC_FRAME_WORDS - 1)])
      else $error("Comma word inside a frame body");

   reset_state: assert property (@(posedge gtx_tx_clk)
      rst |=> ccrx_los && !rx_valid)
      else $error("LOS low or rx_valid high right after reset");

endmodule

bind chitchat_link chitchat_link_properties u_properties (
   .gtx_tx_clk (gtx_tx_clk),
   .rst        (rst),
   .tx_valid   (tx_valid),
   .tx_credit  (tx_credit),
   .gtx_tx_d   (gtx_tx_d),
   .gtx_tx_k   (gtx_tx_k),
   .ccrx_los   (ccrx_los),
   .rx_valid   (rx_valid)
);

// ==== test/chitchat_link_tb.sv ====
/*
 * Link testbench: lane loopback with bit-flip mask, credit model,
 * expected payload queue and directed tests
 */
`timescale 1ns/1ps
`include "chitchat_consts.svh"

module chitchat_link_tb
   import chitchat_pkg::*;
();

   localparam logic [2:0] GW_TYPE  = 3'd6;
   localparam logic [2:0] LOCATION = 3'd5;
   localparam int TIMEOUT_CYCLES   = 4000;

   logic        gtx_tx_clk;
   logic        rst;
   logic        tx_transmit_en;
   logic [2:0]  tx_location;
   logic        tx_valid;
   cc_payload_t tx_payload;
   logic        tx_credit;
   logic        rx_valid;
   cc_payload_t rx_payload;
   cc_rx_info_t rx_info;
   logic [15:0] txrx_latency;
   logic        ccrx_frame_drop;
   cc_fault_e   ccrx_fault;
   logic [15:0] ccrx_fault_cnt;
   logic        ccrx_los;
   logic [15:0] gtx_tx_d;
   logic [1:0]  gtx_tx_k;
   logic [15:0] gtx_rx_d;
   logic [1:0]  gtx_rx_k;
   logic [15:0] err_mask = '0;

   cc_payload_t exp_q[$];
   int errors       = 0;
   int checks       = 0;
   int credits_used = 0;
   int credits_back = 0;
   int rx_count     = 0;
   int drop_count   = 0;
   int cycle_count  = 0;

   // Lane closed externally, one word can be corrupted
   assign gtx_rx_d = gtx_tx_d ^ err_mask;
   assign gtx_rx_k = gtx_tx_k;

   chitchat_link #(
      .GATEWARE_TYPE (GW_TYPE)
   ) dut (.*);

   initial begin
      gtx_tx_clk = 1'b0;
      forever #4 gtx_tx_clk = ~gtx_tx_clk;
   end

   always @(posedge gtx_tx_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run stopped by timeout after %0d cycles", cycle_count);
         $display("Errors: %0d, checks: %0d", errors, checks);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic check_eq(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
      checks++;
      if (got !== expected) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
         errors++;
      end
   endtask

   task automatic fail(input string what);
      $display("Error: %s", what);
      errors++;
   endtask

   // ------------------------------
   // Output monitor
   // ------------------------------
   always @(posedge gtx_tx_clk) begin
      cc_payload_t exp;
      if (!rst) begin
         if (tx_credit)
            credits_back <= credits_back + 1;
         if (ccrx_frame_drop)
            drop_count <= drop_count + 1;
         if (rx_valid) begin
            rx_count <= rx_count + 1;
            if (exp_q.size() == 0) begin
               fail("rx_valid pulsed with no payload outstanding");
            end else begin
               exp = exp_q.pop_front();
               check_eq("rx_payload", rx_payload, exp);
            end
         end
      end
   end

   // Waits for a free credit, then writes one entry
   task automatic send_payload(input cc_payload_t p);
      while (credits_used - credits_back >= `CC_TX_DEPTH)
         @(negedge gtx_tx_clk);
      tx_valid   = 1'b1;
      tx_payload = p;
      exp_q.push_back(p);
      credits_used++;
      @(negedge gtx_tx_clk);
      tx_valid = 1'b0;
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         @(negedge gtx_tx_clk);
         n++;
      end
      if (exp_q.size() != 0)
         fail($sformatf("%0d payloads not received after %0d cycles", exp_q.size(), limit));
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic test_reset_state();
      check_eq("ccrx_los", ccrx_los, 1);
      check_eq("ccrx_fault_cnt", ccrx_fault_cnt, 0);
      check_eq("gtx_tx_k", gtx_tx_k, 0);
      repeat (3 * `CC_FRAME_PERIOD) @(negedge gtx_tx_clk);
      check_eq("rx_valid pulses", rx_count, 0);
      check_eq("tx_credit pulses", credits_back, 0);
   endtask

   task automatic test_round_trip();
      tx_transmit_en = 1'b1;
      repeat (8) send_payload({$urandom, $urandom});
      wait_drain(20 * `CC_FRAME_PERIOD);
      check_eq("rx_info.protocol_ver", rx_info.protocol_ver, `CC_PROTOCOL_VER);
      check_eq("rx_info.gateware_type", rx_info.gateware_type, GW_TYPE);
      check_eq("rx_info.location", rx_info.location, LOCATION);
   endtask

   task automatic test_credits();
      int back_start;
      int seen;
      int waited;
      int last_cycle;
      back_start = credits_back;
      seen       = 0;
      waited     = 0;
      last_cycle = 0;
      for (int i = 0; i < `CC_TX_DEPTH; i++)
         send_payload({$urandom, $urandom});
      // The first credit may already be back while the writes go in
      while (credits_back - back_start < `CC_TX_DEPTH && waited < 8 * `CC_FRAME_PERIOD) begin
         @(negedge gtx_tx_clk);
         waited++;
         if (tx_credit) begin
            // One entry leaves per frame
            if (seen > 0)
               check_eq("tx_credit spacing", cycle_count - last_cycle, `CC_FRAME_PERIOD);
            last_cycle = cycle_count;
            seen++;
         end
      end
      if (credits_back - back_start != `CC_TX_DEPTH)
         fail($sformatf("only %0d of %0d credits came back", credits_back - back_start,
                        `CC_TX_DEPTH));
      wait_drain(4 * `CC_FRAME_PERIOD);
      check_eq("credits available", `CC_TX_DEPTH - (credits_used - credits_back),
               `CC_TX_DEPTH);
   endtask

   task automatic test_empty_frames();
      logic [15:0] fc_start;
      logic [15:0] fc_delta;
      int          rx_start;
      rx_start = rx_count;
      repeat (2 * `CC_FRAME_PERIOD) @(negedge gtx_tx_clk);
      fc_start = rx_info.rx_frame_counter;
      repeat (4 * `CC_FRAME_PERIOD) @(negedge gtx_tx_clk);
      fc_delta = rx_info.rx_frame_counter - fc_start;
      check_eq("rx_frame_counter advance", fc_delta, 4);
      check_eq("rx_valid pulses", rx_count - rx_start, 0);
      check_eq("ccrx_los", ccrx_los, 0);
      check_eq("txrx_latency", txrx_latency, 1);
   endtask

   task automatic test_corruption();
      logic [15:0] cnt_start;
      int          rx_start;
      int          n;
      cnt_start = ccrx_fault_cnt;
      rx_start  = rx_count;
      n         = 0;
      send_payload({$urandom, $urandom});
      // Credit comes back while the comma of that frame is on the lane
      while (!tx_credit && n < 3 * `CC_FRAME_PERIOD) begin
         @(negedge gtx_tx_clk);
         n++;
      end
      if (!tx_credit) begin
         fail("no credit returned for the payload to corrupt");
      end else begin
         check_eq("gtx_tx_k at credit", gtx_tx_k, 2'b01);
         check_eq("gtx_tx_d at credit", gtx_tx_d, {8'h00, `CC_COMMA});
         // Comma, header, then data0 high half
         repeat (2) @(negedge gtx_tx_clk);
         err_mask = 16'h0010;
         @(negedge gtx_tx_clk);
         err_mask = '0;
         n = 0;
         while (!ccrx_frame_drop && n < `CC_FRAME_PERIOD) begin
            @(negedge gtx_tx_clk);
            n++;
         end
         if (!ccrx_frame_drop) begin
            fail("corrupted frame was not dropped");
         end else begin
            check_eq("ccrx_fault", ccrx_fault, FAULT_CHECKSUM);
            check_eq("ccrx_fault_cnt", ccrx_fault_cnt, cnt_start + 16'd1);
         end
         void'(exp_q.pop_back());
      end
      repeat (2) @(negedge gtx_tx_clk);
      check_eq("rx_valid pulses", rx_count - rx_start, 0);
      check_eq("credits available", `CC_TX_DEPTH - (credits_used - credits_back),
               `CC_TX_DEPTH);
   endtask

   task automatic test_los();
      int n;
      check_eq("ccrx_los", ccrx_los, 0);
      tx_transmit_en = 1'b0;
      n = 0;
      while (!ccrx_los && n < `CC_LOS_TIMEOUT + `CC_FRAME_PERIOD) begin
         @(negedge gtx_tx_clk);
         n++;
      end
      if (!ccrx_los)
         fail("ccrx_los did not rise after transmission stopped");
      tx_transmit_en = 1'b1;
      n = 0;
      while (ccrx_los && n < 2 * `CC_FRAME_PERIOD) begin
         @(negedge gtx_tx_clk);
         n++;
      end
      if (ccrx_los)
         fail("ccrx_los did not clear after transmission resumed");
   endtask

   initial begin
      void'($urandom(43));
      rst            = 1'b1;
      tx_transmit_en = 1'b0;
      tx_location    = LOCATION;
      tx_valid       = 1'b0;
      tx_payload     = '0;
      repeat (16) @(negedge gtx_tx_clk);
      rst = 1'b0;

      test_reset_state();
      test_round_trip();
      test_credits();
      test_empty_frames();
      test_corruption();
      test_los();

      // Only the corrupted frame may have been dropped
      check_eq("drop count", drop_count, 1);
      check_eq("ccrx_fault_cnt", ccrx_fault_cnt, 1);

      $display("Errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
